/* verilog/cost_pkg.sv */
// Cost cluster package with block geometry, store sizes and payload types
package cost_pkg;

    // ------------------------------------------------------------------
    // Block geometry and sample widths
    // ------------------------------------------------------------------
    localparam int BLOCK_SIZE  = 4;
    localparam int NUM_SAMPLES = BLOCK_SIZE * BLOCK_SIZE;
    localparam int SAMPLE_W    = 8;
    localparam int WEIGHT_W    = 16;
    localparam int COST_W      = 32;

    // Two butterfly passes add four bits and the sign needs one more
    localparam int TRANSFORM_W = SAMPLE_W + 5;

    // ------------------------------------------------------------------
    // Store sizes
    // ------------------------------------------------------------------
    localparam int BLK_ADDR_W  = 4;
    localparam int WSET_ADDR_W = 2;
    localparam int BLK_DEPTH   = 1 << BLK_ADDR_W;
    localparam int WSET_DEPTH  = 1 << WSET_ADDR_W;

    localparam int NUM_ENGINES = 2;

    // ------------------------------------------------------------------
    // Payloads
    // ------------------------------------------------------------------
    // Sample 0 in the lowest byte, row-major
    typedef logic [NUM_SAMPLES*SAMPLE_W-1:0] sample_block_t;

    // Weight 0 in the lowest 16 bits, each weight signed
    typedef logic [NUM_SAMPLES*WEIGHT_W-1:0] weight_set_t;

endpackage

/* verilog/block_store.sv */
// Single-write single-read entry store with a registered read port
`timescale 1ns/10ps

module block_store #(
    parameter type entry_t = logic [7:0],
    parameter int  DEPTH   = 16,
    parameter int  ADDR_W  = 4
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              wr_en_i,
    input  logic [ADDR_W-1:0] wr_addr_i,
    input  entry_t            wr_data_i,
    input  logic              rd_en_i,
    input  logic [ADDR_W-1:0] rd_addr_i,
    output entry_t            rd_data_o
);

    entry_t mem [DEPTH];

    // Host write port
    always_ff @(posedge clk) begin
        if (wr_en_i) begin
            mem[wr_addr_i] <= wr_data_i;
        end
    end

    // Read data is valid the cycle after rd_en_i and holds until the next read
    always_ff @(posedge clk) begin
        if (rd_en_i) begin
            rd_data_o <= mem[rd_addr_i];
        end
    end

    // Host must leave a slot alone while an engine fetches it
    a_no_wr_rd_collision : assert property (
        @(posedge clk) disable iff (!rst_n)
        !(wr_en_i && rd_en_i && (wr_addr_i == rd_addr_i))
    ) else $error("block_store: write and read to address %0d in one cycle", wr_addr_i);

endmodule

/* verilog/store_arbiter.sv */
// Round-robin arbiter that hands the shared store read port to one engine
`timescale 1ns/10ps

module store_arbiter
    import cost_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic [NUM_ENGINES-1:0] req_i,
    input  logic [BLK_ADDR_W-1:0]  blk_addr0_i,
    input  logic [BLK_ADDR_W-1:0]  blk_addr1_i,
    input  logic [WSET_ADDR_W-1:0] wset0_i,
    input  logic [WSET_ADDR_W-1:0] wset1_i,
    output logic [NUM_ENGINES-1:0] grant_o,
    output logic                   rd_en_o,
    output logic [BLK_ADDR_W-1:0]  blk_rd_addr_o,
    output logic [WSET_ADDR_W-1:0] w_rd_addr_o
);

    // Engine that won the last grant
    logic last_q;

    // ------------------------------------------------------------------
    // Grant selection
    // ------------------------------------------------------------------
    always_comb begin
        grant_o = '0;
        if (req_i[0] && req_i[1]) begin
            // Contested, so the engine that did not win last time goes first
            if (last_q) begin
                grant_o[0] = 1'b1;
            end else begin
                grant_o[1] = 1'b1;
            end
        end else if (req_i[0]) begin
            grant_o[0] = 1'b1;
        end else if (req_i[1]) begin
            grant_o[1] = 1'b1;
        end
    end

    // Reset value favours engine 0 on the first contest
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            last_q <= 1'b1;
        end else if (|grant_o) begin
            last_q <= grant_o[1];
        end
    end

    // ------------------------------------------------------------------
    // Shared read port
    // ------------------------------------------------------------------
    assign rd_en_o = |grant_o;

    always_comb begin
        if (grant_o[1]) begin
            blk_rd_addr_o = blk_addr1_i;
            w_rd_addr_o   = wset1_i;
        end else begin
            blk_rd_addr_o = blk_addr0_i;
            w_rd_addr_o   = wset0_i;
        end
    end

    a_grant_onehot0 : assert property (
        @(posedge clk) disable iff (!rst_n)
        $onehot0(grant_o)
    ) else $error("store_arbiter: more than one grant, grant_o = %b", grant_o);

endmodule

/* verilog/satd_core.sv */
// 4x4 Hadamard transform with absolute values and a signed weighted sum
`timescale 1ns/10ps

module satd_core
    import cost_pkg::*;
(
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     start_i,
    input  sample_block_t            block_i,
    input  weight_set_t              weights_i,
    output logic signed [COST_W-1:0] cost_o,
    output logic                     done_o
);

    logic signed [TRANSFORM_W-1:0] row_c [NUM_SAMPLES];
    logic signed [TRANSFORM_W-1:0] col_c [NUM_SAMPLES];
    logic        [TRANSFORM_W-1:0] abs_q [NUM_SAMPLES];
    logic signed [WEIGHT_W-1:0]    w_q   [NUM_SAMPLES];
    logic signed [COST_W-1:0]      sum_d;
    logic                          stg1_q;

    // Zero-extended sample idx of a block
    function automatic logic signed [TRANSFORM_W-1:0] sample_at(
        input sample_block_t blk,
        input int            idx
    );
        return TRANSFORM_W'(blk[idx*SAMPLE_W +: SAMPLE_W]);
    endfunction

    // 4-point butterfly, same ordering for rows and columns
    function automatic void bfly4(
        input  logic signed [TRANSFORM_W-1:0] x0,
        input  logic signed [TRANSFORM_W-1:0] x1,
        input  logic signed [TRANSFORM_W-1:0] x2,
        input  logic signed [TRANSFORM_W-1:0] x3,
        output logic signed [TRANSFORM_W-1:0] y0,
        output logic signed [TRANSFORM_W-1:0] y1,
        output logic signed [TRANSFORM_W-1:0] y2,
        output logic signed [TRANSFORM_W-1:0] y3
    );
        logic signed [TRANSFORM_W-1:0] a0;
        logic signed [TRANSFORM_W-1:0] a1;
        logic signed [TRANSFORM_W-1:0] a2;
        logic signed [TRANSFORM_W-1:0] a3;
        a0 = x0 + x2;
        a1 = x1 + x3;
        a2 = x1 - x3;
        a3 = x0 - x2;
        y0 = a0 + a1;
        y1 = a3 + a2;
        y2 = a3 - a2;
        y3 = a0 - a1;
    endfunction

    // ------------------------------------------------------------------
    // Stage 1 transform and absolute value
    // ------------------------------------------------------------------
    always_comb begin
        for (int r = 0; r < BLOCK_SIZE; r++) begin
            bfly4(sample_at(block_i, r*BLOCK_SIZE + 0), sample_at(block_i, r*BLOCK_SIZE + 1),
                  sample_at(block_i, r*BLOCK_SIZE + 2), sample_at(block_i, r*BLOCK_SIZE + 3),
                  row_c[r*BLOCK_SIZE + 0], row_c[r*BLOCK_SIZE + 1],
                  row_c[r*BLOCK_SIZE + 2], row_c[r*BLOCK_SIZE + 3]);
        end
    end

    always_comb begin
        for (int c = 0; c < BLOCK_SIZE; c++) begin
            bfly4(row_c[c], row_c[BLOCK_SIZE + c], row_c[2*BLOCK_SIZE + c],
                  row_c[3*BLOCK_SIZE + c],
                  col_c[c], col_c[BLOCK_SIZE + c], col_c[2*BLOCK_SIZE + c],
                  col_c[3*BLOCK_SIZE + c]);
        end
    end

    // Captures the shared store buses only on start
    always_ff @(posedge clk) begin
        if (start_i) begin
            for (int k = 0; k < NUM_SAMPLES; k++) begin
                abs_q[k] <= (col_c[k] < 0) ? TRANSFORM_W'(-col_c[k]) : TRANSFORM_W'(col_c[k]);
                w_q[k]   <= weights_i[k*WEIGHT_W +: WEIGHT_W];
            end
        end
    end

    // ------------------------------------------------------------------
    // Stage 2 weighted sum
    // ------------------------------------------------------------------
    always_comb begin
        sum_d = '0;
        for (int k = 0; k < NUM_SAMPLES; k++) begin
            sum_d = sum_d + $signed({1'b0, abs_q[k]}) * w_q[k];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            stg1_q <= 1'b0;
            done_o <= 1'b0;
            cost_o <= '0;
        end else begin
            stg1_q <= start_i;
            done_o <= stg1_q;
            if (stg1_q) begin
                cost_o <= sum_d;
            end
        end
    end

endmodule

/* verilog/cost_engine.sv */
// Cost engine job control that fetches a block and weight set and runs the core
`timescale 1ns/10ps

module cost_engine
    import cost_pkg::*;
(
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     job_valid_i,
    input  logic [BLK_ADDR_W-1:0]    job_blk_i,
    input  logic [WSET_ADDR_W-1:0]   job_wset_i,
    output logic                     busy_o,
    output logic                     req_o,
    output logic [BLK_ADDR_W-1:0]    req_blk_o,
    output logic [WSET_ADDR_W-1:0]   req_wset_o,
    input  logic                     grant_i,
    input  sample_block_t            blk_data_i,
    input  weight_set_t              w_data_i,
    output logic signed [COST_W-1:0] cost_o,
    output logic                     cost_valid_o
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_REQ,
        ST_DATA,
        ST_CALC
    } state_t;

    state_t                  state_q;
    state_t                  state_d;
    logic [BLK_ADDR_W-1:0]   blk_q;
    logic [WSET_ADDR_W-1:0]  wset_q;
    logic                    core_start;

    // ------------------------------------------------------------------
    // Job FSM
    // ------------------------------------------------------------------
    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE: if (job_valid_i) state_d = ST_REQ;
            ST_REQ:  if (grant_i) state_d = ST_DATA;
            ST_DATA: state_d = ST_CALC;
            // Core result lands one cycle later, in step with IDLE
            ST_CALC: state_d = ST_IDLE;
            default: state_d = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= ST_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // Job addresses held for the arbiter
    always_ff @(posedge clk) begin
        if (job_valid_i && (state_q == ST_IDLE)) begin
            blk_q  <= job_blk_i;
            wset_q <= job_wset_i;
        end
    end

    assign busy_o     = (state_q != ST_IDLE);
    assign req_o      = (state_q == ST_REQ);
    assign req_blk_o  = blk_q;
    assign req_wset_o = wset_q;

    // Store data is on the shared buses the cycle after our grant
    assign core_start = (state_q == ST_DATA);

    // ------------------------------------------------------------------
    // Transform core
    // ------------------------------------------------------------------
    satd_core satd_core_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .start_i   (core_start),
        .block_i   (blk_data_i),
        .weights_i (w_data_i),
        .cost_o    (cost_o),
        .done_o    (cost_valid_o)
    );

    a_job_when_idle : assert property (
        @(posedge clk) disable iff (!rst_n)
        job_valid_i |-> !busy_o
    ) else $error("cost_engine: job pulse while busy");

    // Store read, core start and core sum each take one cycle
    a_grant_to_result : assert property (
        @(posedge clk) disable iff (!rst_n)
        grant_i |-> ##3 cost_valid_o
    ) else $error("cost_engine: no result three cycles after grant");

endmodule

/* verilog/satd_cluster.sv */
// Cost cluster top with the sample and weight stores, arbiter and two engines
`timescale 1ns/10ps

module satd_cluster
    import cost_pkg::*;
(
    input  logic                     clk,
    input  logic                     rst_n,
    // Host write ports
    input  logic                     blk_wr_en_i,
    input  logic [BLK_ADDR_W-1:0]    blk_wr_addr_i,
    input  sample_block_t            blk_wr_data_i,
    input  logic                     w_wr_en_i,
    input  logic [WSET_ADDR_W-1:0]   w_wr_addr_i,
    input  weight_set_t              w_wr_data_i,
    // Engine 0
    input  logic                     job_valid_0_i,
    input  logic [BLK_ADDR_W-1:0]    job_blk_0_i,
    input  logic [WSET_ADDR_W-1:0]   job_wset_0_i,
    output logic                     busy_0_o,
    output logic signed [COST_W-1:0] cost_0_o,
    output logic                     cost_valid_0_o,
    // Engine 1
    input  logic                     job_valid_1_i,
    input  logic [BLK_ADDR_W-1:0]    job_blk_1_i,
    input  logic [WSET_ADDR_W-1:0]   job_wset_1_i,
    output logic                     busy_1_o,
    output logic signed [COST_W-1:0] cost_1_o,
    output logic                     cost_valid_1_o
);

    logic [NUM_ENGINES-1:0] req;
    logic [NUM_ENGINES-1:0] grant;
    logic [BLK_ADDR_W-1:0]  req_blk_0;
    logic [BLK_ADDR_W-1:0]  req_blk_1;
    logic [WSET_ADDR_W-1:0] req_wset_0;
    logic [WSET_ADDR_W-1:0] req_wset_1;
    logic                   rd_en;
    logic [BLK_ADDR_W-1:0]  blk_rd_addr;
    logic [WSET_ADDR_W-1:0] w_rd_addr;
    sample_block_t          blk_rd_data;
    weight_set_t            w_rd_data;

    // ------------------------------------------------------------------
    // Stores
    // ------------------------------------------------------------------
    block_store #(
        .entry_t (sample_block_t),
        .DEPTH   (BLK_DEPTH),
        .ADDR_W  (BLK_ADDR_W)
    ) sample_store_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .wr_en_i   (blk_wr_en_i),
        .wr_addr_i (blk_wr_addr_i),
        .wr_data_i (blk_wr_data_i),
        .rd_en_i   (rd_en),
        .rd_addr_i (blk_rd_addr),
        .rd_data_o (blk_rd_data)
    );

    block_store #(
        .entry_t (weight_set_t),
        .DEPTH   (WSET_DEPTH),
        .ADDR_W  (WSET_ADDR_W)
    ) weight_store_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .wr_en_i   (w_wr_en_i),
        .wr_addr_i (w_wr_addr_i),
        .wr_data_i (w_wr_data_i),
        .rd_en_i   (rd_en),
        .rd_addr_i (w_rd_addr),
        .rd_data_o (w_rd_data)
    );

    store_arbiter store_arbiter_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .req_i         (req),
        .blk_addr0_i   (req_blk_0),
        .blk_addr1_i   (req_blk_1),
        .wset0_i       (req_wset_0),
        .wset1_i       (req_wset_1),
        .grant_o       (grant),
        .rd_en_o       (rd_en),
        .blk_rd_addr_o (blk_rd_addr),
        .w_rd_addr_o   (w_rd_addr)
    );

    // ------------------------------------------------------------------
    // Engines share the store data buses
    // ------------------------------------------------------------------
    cost_engine cost_engine_0_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .job_valid_i  (job_valid_0_i),
        .job_blk_i    (job_blk_0_i),
        .job_wset_i   (job_wset_0_i),
        .busy_o       (busy_0_o),
        .req_o        (req[0]),
        .req_blk_o    (req_blk_0),
        .req_wset_o   (req_wset_0),
        .grant_i      (grant[0]),
        .blk_data_i   (blk_rd_data),
        .w_data_i     (w_rd_data),
        .cost_o       (cost_0_o),
        .cost_valid_o (cost_valid_0_o)
    );

    cost_engine cost_engine_1_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .job_valid_i  (job_valid_1_i),
        .job_blk_i    (job_blk_1_i),
        .job_wset_i   (job_wset_1_i),
        .busy_o       (busy_1_o),
        .req_o        (req[1]),
        .req_blk_o    (req_blk_1),
        .req_wset_o   (req_wset_1),
        .grant_i      (grant[1]),
        .blk_data_i   (blk_rd_data),
        .w_data_i     (w_rd_data),
        .cost_o       (cost_1_o),
        .cost_valid_o (cost_valid_1_o)
    );

endmodule

/* verification/tb_clock.sv */
// Testbench clock and reset generator with a fixed reset length
`timescale 1ns/10ps

module tb_clock #(
    parameter int PERIOD_NS    = 20,
    parameter int RESET_CYCLES = 16
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever begin
            #(PERIOD_NS / 2) clk = ~clk;
        end
    end

    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
    end

endmodule

/* verification/tb_checker.sv */
// Result monitor that compares engine costs against per-engine expected queues
`timescale 1ns/10ps

module tb_checker
    import cost_pkg::*;
(
    input logic                     clk,
    input logic                     rst_n,
    input logic                     idle_window_i,
    input logic                     busy_0_i,
    input logic                     busy_1_i,
    input logic                     cost_valid_0_i,
    input logic signed [COST_W-1:0] cost_0_i,
    input logic                     cost_valid_1_i,
    input logic signed [COST_W-1:0] cost_1_i
);

    logic signed [COST_W-1:0] exp0_q [$];
    logic signed [COST_W-1:0] exp1_q [$];
    int   checked_count = 0;
    int   error_count   = 0;
    logic idle_fault    = 1'b0;

    task automatic push_expected(input int eng, input logic signed [COST_W-1:0] cost);
        if (eng == 0) begin
            exp0_q.push_back(cost);
        end else begin
            exp1_q.push_back(cost);
        end
    endtask

    function automatic int outstanding();
        return exp0_q.size() + exp1_q.size();
    endfunction

    task automatic check_result(input int eng, input logic signed [COST_W-1:0] got);
        logic signed [COST_W-1:0] exp;
        string                    name;
        name = (eng == 0) ? "cost_0_o" : "cost_1_o";
        if ((eng == 0 && exp0_q.size() == 0) || (eng == 1 && exp1_q.size() == 0)) begin
            $display("Engine %0d returned a result at %0t ns with no job outstanding",
                     eng, $time);
            error_count++;
        end else begin
            if (eng == 0) begin
                exp = exp0_q.pop_front();
            end else begin
                exp = exp1_q.pop_front();
            end
            checked_count++;
            if (got !== exp) begin
                $display("** Error at %0t ns: %s = %0d, expected %0d", $time, name, got, exp);
                error_count++;
            end else begin
                $display("Job %0d on engine %0d: cost %0d as expected", checked_count, eng, got);
            end
        end
    endtask

    // ------------------------------------------------------------------
    // Outputs are registered, so sample them on the falling edge
    // ------------------------------------------------------------------
    always @(negedge clk) begin
        if (rst_n) begin
            if (cost_valid_0_i) begin
                check_result(0, cost_0_i);
            end
            if (cost_valid_1_i) begin
                check_result(1, cost_1_i);
            end
            // Nothing may move before the first job
            if (idle_window_i && !idle_fault &&
                (busy_0_i || busy_1_i || cost_valid_0_i || cost_valid_1_i)) begin
                $display("Engine became busy or gave a result at %0t ns before any job",
                         $time);
                idle_fault = 1'b1;
                error_count++;
            end
        end
    end

    task automatic print_summary();
        $display("Summary: %0d jobs checked, %0d errors, %0d results missing",
                 checked_count, error_count, outstanding());
    endtask

endmodule

/* verification/tb_satd_cluster.sv */
// Testbench top for the cost cluster driven from the golden record file
`timescale 1ns/10ps

module tb_satd_cluster
    import cost_pkg::*;
();

    localparam int RESET_CYCLES   = 16;
    localparam int CYCLES_PER_JOB = 12;
    localparam int MARGIN_CYCLES  = 50;

    logic                   clk;
    logic                   rst_n;
    logic                   blk_wr_en_i;
    logic [BLK_ADDR_W-1:0]  blk_wr_addr_i;
    sample_block_t          blk_wr_data_i;
    logic                   w_wr_en_i;
    logic [WSET_ADDR_W-1:0] w_wr_addr_i;
    weight_set_t            w_wr_data_i;
    logic                   job_valid_0_i;
    logic [BLK_ADDR_W-1:0]  job_blk_0_i;
    logic [WSET_ADDR_W-1:0] job_wset_0_i;
    logic                   job_valid_1_i;
    logic [BLK_ADDR_W-1:0]  job_blk_1_i;
    logic [WSET_ADDR_W-1:0] job_wset_1_i;
    logic                   busy_0_o;
    logic                   busy_1_o;
    logic signed [COST_W-1:0] cost_0_o;
    logic signed [COST_W-1:0] cost_1_o;
    logic                   cost_valid_0_o;
    logic                   cost_valid_1_o;
    logic                   idle_window;

    // Golden records in file order
    string        kind_q [$];
    int           a_q    [$];
    int           b_q    [$];
    int           c_q    [$];
    logic [255:0] data_q [$];
    logic [31:0]  cost_q [$];

    // Pending jobs per engine
    int          blk0_q [$];
    int          wset0_q [$];
    logic [31:0] exp0_q [$];
    int          blk1_q [$];
    int          wset1_q [$];
    logic [31:0] exp1_q [$];

    logic [31:0] seed = 32'h73e4;
    int   cycle_count = 0;
    int   cycle_limit = 0;
    int   job_total   = 0;
    int   load_total  = 0;
    logic file_ok     = 1'b0;

    tb_clock #(.PERIOD_NS(20), .RESET_CYCLES(RESET_CYCLES)) tb_clock_i (
        .clk   (clk),
        .rst_n (rst_n)
    );

    satd_cluster satd_cluster_i (.*);

    tb_checker tb_checker_i (
        .clk            (clk),
        .rst_n          (rst_n),
        .idle_window_i  (idle_window),
        .busy_0_i       (busy_0_o),
        .busy_1_i       (busy_1_o),
        .cost_valid_0_i (cost_valid_0_o),
        .cost_0_i       (cost_0_o),
        .cost_valid_1_i (cost_valid_1_o),
        .cost_1_i       (cost_1_o)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic read_golden();
        int           fd;
        int           n;
        string        line;
        string        tag;
        int           a;
        int           b;
        int           c;
        logic [255:0] data;
        logic [31:0]  cost;
        fd = $fopen("verification/satd_golden.dat", "r");
        if (fd != 0) begin
            file_ok = 1'b1;
            while (!$feof(fd)) begin
                line = "";
                n = $fgets(line, fd);
                if (line.len() == 0 || line.getc(0) == "#") continue;
                n = $sscanf(line, "%s", tag);
                if (n < 1) continue;
                a = 0;
                b = 0;
                c = 0;
                data = '0;
                cost = '0;
                if (tag == "B" || tag == "W") begin
                    n = $sscanf(line, "%s %d %h", tag, a, data);
                    load_total++;
                end else if (tag == "J") begin
                    n = $sscanf(line, "%s %d %d %d %h", tag, a, b, c, cost);
                    job_total++;
                end
                kind_q.push_back(tag);
                a_q.push_back(a);
                b_q.push_back(b);
                c_q.push_back(c);
                data_q.push_back(data);
                cost_q.push_back(cost);
            end
            $fclose(fd);
        end
    endtask

    task automatic end_writes();
        @(posedge clk);
        blk_wr_en_i <= 1'b0;
        w_wr_en_i   <= 1'b0;
    endtask

    // ------------------------------------------------------------------
    // Job dispatch with random gaps and an occasional hold for a joint launch
    // ------------------------------------------------------------------
    task automatic run_jobs();
        int   gap0;
        int   gap1;
        logic just0;
        logic just1;
        logic go0;
        logic go1;
        gap0 = 0;
        gap1 = 0;
        just0 = 1'b0;
        just1 = 1'b0;
        while (blk0_q.size() > 0 || blk1_q.size() > 0) begin
            @(negedge clk);
            seed = xorshift32(seed);
            go0 = blk0_q.size() > 0 && !busy_0_o && !just0 && gap0 == 0;
            go1 = blk1_q.size() > 0 && !busy_1_o && !just1 && gap1 == 0;
            if (!busy_0_o && !just0 && gap0 > 0) gap0--;
            if (!busy_1_o && !just1 && gap1 > 0) gap1--;
            if (go0 && !go1 && blk1_q.size() > 0 && seed[1:0] == 2'd0) go0 = 1'b0;
            if (go1 && !go0 && blk0_q.size() > 0 && seed[3:2] == 2'd0) go1 = 1'b0;
            @(posedge clk);
            job_valid_0_i <= go0;
            job_valid_1_i <= go1;
            if (go0) begin
                idle_window = 1'b0;
                job_blk_0_i  <= BLK_ADDR_W'(blk0_q.pop_front());
                job_wset_0_i <= WSET_ADDR_W'(wset0_q.pop_front());
                tb_checker_i.push_expected(0, exp0_q.pop_front());
                gap0 = int'(seed[5:4]);
            end
            if (go1) begin
                idle_window = 1'b0;
                job_blk_1_i  <= BLK_ADDR_W'(blk1_q.pop_front());
                job_wset_1_i <= WSET_ADDR_W'(wset1_q.pop_front());
                tb_checker_i.push_expected(1, exp1_q.pop_front());
                gap1 = int'(seed[7:6]);
            end
            just0 = go0;
            just1 = go1;
        end
        @(posedge clk);
        job_valid_0_i <= 1'b0;
        job_valid_1_i <= 1'b0;
        while (busy_0_o || busy_1_o || tb_checker_i.outstanding() > 0) @(negedge clk);
    endtask

    initial begin
        blk_wr_en_i   = 1'b0;
        blk_wr_addr_i = '0;
        blk_wr_data_i = '0;
        w_wr_en_i     = 1'b0;
        w_wr_addr_i   = '0;
        w_wr_data_i   = '0;
        job_valid_0_i = 1'b0;
        job_blk_0_i   = '0;
        job_wset_0_i  = '0;
        job_valid_1_i = 1'b0;
        job_blk_1_i   = '0;
        job_wset_1_i  = '0;
        idle_window   = 1'b1;
        read_golden();
        cycle_limit = RESET_CYCLES + load_total + CYCLES_PER_JOB * job_total + MARGIN_CYCLES;
        if (!file_ok) begin
            $display("Could not open the golden file");
            $display("Testbench failed");
            $finish;
        end else begin
            wait (rst_n);
            for (int i = 0; i < kind_q.size(); i++) begin
                if (kind_q[i] == "B") begin
                    @(posedge clk);
                    w_wr_en_i     <= 1'b0;
                    blk_wr_en_i   <= 1'b1;
                    blk_wr_addr_i <= BLK_ADDR_W'(a_q[i]);
                    blk_wr_data_i <= data_q[i][127:0];
                end else if (kind_q[i] == "W") begin
                    @(posedge clk);
                    blk_wr_en_i <= 1'b0;
                    w_wr_en_i   <= 1'b1;
                    w_wr_addr_i <= WSET_ADDR_W'(a_q[i]);
                    w_wr_data_i <= data_q[i];
                end else if (kind_q[i] == "J" && a_q[i] == 0) begin
                    blk0_q.push_back(b_q[i]);
                    wset0_q.push_back(c_q[i]);
                    exp0_q.push_back(cost_q[i]);
                end else if (kind_q[i] == "J") begin
                    blk1_q.push_back(b_q[i]);
                    wset1_q.push_back(c_q[i]);
                    exp1_q.push_back(cost_q[i]);
                end else if (kind_q[i] == "S") begin
                    end_writes();
                    run_jobs();
                end
            end
            end_writes();
            run_jobs();
            tb_checker_i.print_summary();
            if (tb_checker_i.error_count == 0 && tb_checker_i.checked_count == job_total) begin
                $display("Testbench passed");
            end else begin
                $display("Testbench failed");
            end
            $finish;
        end
    end

    // Run limit from the record and job counts
    always @(posedge clk) begin
        cycle_count++;
        if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
            $display("Run stopped after %0d cycles without finishing all jobs", cycle_count);
            tb_checker_i.print_summary();
            $display("Testbench failed");
            $finish;
        end
    end

endmodule

/* project.f */
verilog/cost_pkg.sv
verilog/block_store.sv
verilog/store_arbiter.sv
verilog/satd_core.sv
verilog/cost_engine.sv
verilog/satd_cluster.sv
verification/tb_clock.sv
verification/tb_checker.sv
verification/tb_satd_cluster.sv

/* verification/satd_golden.dat */
# B addr block_hex(sample15..sample0) | W index weights_hex(weight15..weight0)
# J engine block wset expected_cost_hex | S waits until all jobs are done
B 0 00000000000000000000000000000000
B 1 10101010101010101010101010101010
B 2 7f7f7f7f7f7f7f7f7f7f7f7f7f7f7f7f
B 3 000000000000000000000000000000ff
B 4 00000000000000000000800000000000
B 5 00ff00ff00ff00ff00ff00ff00ff00ff
B 6 10101010101010101010101010101010
W 0 0001000100010001000100010001000100010001000100010001000100010001
W 1 fffe0003fffe0003fffe0003fffe0003fffe0003fffe0003fffe0003fffe0003
W 2 ffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffff
W 3 ff00ff00ff00ff00ff00ff00ff00ff00ff00ff00ff00ff00ff00ff00ff000100
J 0 0 0 00000000
J 0 1 0 00000100
J 0 2 3 0007f000
J 0 3 3 fff20e00
J 0 4 2 fffff800
J 0 5 2 fffff010
J 1 3 1 000007f8
J 1 4 1 00000400
J 1 5 1 000007f8
J 1 6 0 00000100
S
J 0 2 1 000017d0
J 1 1 2 ffffff00
J 0 6 1 00000300
S
B 6 20202020202020202020202020202020
J 0 6 1 00000600
J 1 6 0 00000200
S
